// ==== tb/issue_cases.txt ====
# gap fu(0 alu, 1 mult) op(0 add, 1 sub, 2 and, 3 xor) rdy1 val1 rdy2 val2 dest
# val is hex, and names an earlier dest tag when rdy is 0; gap and dest are decimal
0 0 0 1 00000005 1 00000007 0
0 0 1 1 00000003 1 0000000a 1
0 0 2 1 f0f0ff00 1 0ff00ff0 2
0 0 3 1 12345678 1 ffffffff 3
4 1 0 1 00000006 1 00000007 4
0 0 0 0 00000004 1 00000001 5
0 1 0 0 00000005 1 00000003 6
6 0 0 1 00000010 1 00000020 7
2 0 3 0 00000007 1 000000ff 8
0 1 0 0 00000008 0 00000006 9
0 0 1 0 00000009 1 00000001 10
3 1 0 1 00001234 1 00005678 11
0 1 0 1 ffffffff 1 00000002 12
0 1 0 1 80000001 1 00000003 13
2 1 0 1 00000011 1 00000013 14
0 1 0 0 0000000e 1 00000002 15
0 1 0 0 0000000e 1 00000003 16
0 1 0 1 00000005 0 0000000e 17
0 1 0 0 0000000e 0 0000000e 18
0 1 0 0 0000000e 1 00000007 19
0 1 0 0 0000000c 0 0000000e 20
0 1 0 0 0000000e 1 ffffffff 21
0 0 0 0 00000015 0 00000014 22

// ==== compile.f ====
logic/issue_params_pkg.sv
logic/issue_types_pkg.sv
logic/psel_gen.sv
logic/rs.sv
logic/fu_alu.sv
logic/fu_mult.sv
logic/issue_core.sv
tb/tb_clock.sv
tb/issue_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb \
    -Mdir obj_dir -f compile.f

output="$(./obj_dir/Vissue_core_tb || true)"
echo "$output"

if grep -qF '*** TEST PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb/issue_core_tb.sv ====
module issue_core_tb;

    import issue_params_pkg::*;
    import issue_types_pkg::*;

    localparam int max_cases = 32;   // one case per tag

    logic                    clock;
    logic                    reset;
    dispatch_packet_t        dispatch;
    logic                    almost_full;
    cdb_packet_t [n_way-1:0] cdb;

    int              n_cases;
    int              gap_q[max_cases];
    rs_entry_t       uop_q[max_cases];       // file order
    rs_entry_t       uop_of_tag[max_cases];
    bit              known[max_cases];
    logic [xlen-1:0] exp_val[max_cases];     // by tag
    int              seen[max_cases];
    int              n_results;
    int              driven;
    int              cycle;
    int              last_mult = -100;
    bit              loaded;

    tb_clock #(.period(8)) i_clock (.clock(clock));

    issue_core i_issue_core (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .almost_full (almost_full),
        .cdb         (cdb)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cdb(input cdb_packet_t pkt, input logic [xlen-1:0] expected);
        if (pkt.value !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: tag %0d value %h, expected %h",
                                $time, pkt.tag, pkt.value, expected));
        end
    endtask

    task automatic check_level(input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: almost_full %b, expected %b",
                                $time, actual, expected));
        end
    endtask

    function automatic logic [xlen-1:0] reference(rs_entry_t u, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
        if (u.fu == fu_mult) return a * b;   // low half of the product
        case (u.op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic load_cases();
        int              fd;
        int              count;
        int              g, f, o, r1, r2, d;
        logic [xlen-1:0] v1, v2, a, b;
        string           line;
        rs_entry_t       u;
        fd = $fopen("tb/issue_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the cases file tb/issue_cases.txt");
        end else begin
            n_cases = 0;
            while (!$feof(fd) && n_cases < max_cases) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    count = $sscanf(line, "%d %d %d %d %h %d %h %d", g, f, o, r1, v1, r2, v2, d);
                    if (count == 8) begin   // comment and blank lines fall through
                        u          = '0;
                        u.valid    = 1'b1;
                        u.fu       = fu_kind_e'(f);
                        u.op       = alu_op_e'(o);
                        u.op1      = '{ready: r1[0], data: v1};
                        u.op2      = '{ready: r2[0], data: v2};
                        u.dest_tag = d[tag_width-1:0];
                        a = r1[0] ? v1 : exp_val[v1[tag_width-1:0]];
                        b = r2[0] ? v2 : exp_val[v2[tag_width-1:0]];
                        exp_val[d]    = reference(u, a, b);
                        uop_of_tag[d] = u;
                        known[d]      = 1'b1;
                        gap_q[n_cases] = g;
                        uop_q[n_cases] = u;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    endtask

    task automatic record_result(input int slot, input cdb_packet_t pkt);
        rs_entry_t u;
        u = uop_of_tag[pkt.tag];
        if (!known[pkt.tag]) begin
            abort_run($sformatf("result for tag %0d that was never dispatched", pkt.tag));
        end else if (seen[pkt.tag] != 0) begin
            abort_run($sformatf("tag %0d was broadcast a second time", pkt.tag));
        end else if (slot != (u.fu == fu_mult ? 1 : 0)) begin
            abort_run($sformatf("tag %0d came out on the wrong CDB slot", pkt.tag));
        end else if ((!u.op1.ready && seen[u.op1.data[tag_width-1:0]] == 0) ||
                     (!u.op2.ready && seen[u.op2.data[tag_width-1:0]] == 0)) begin
            abort_run($sformatf("tag %0d appeared before a result it needs", pkt.tag));
        end else if (u.fu == fu_mult && cycle - last_mult < mult_cycles) begin
            abort_run($sformatf("multiply tag %0d followed the last one too soon", pkt.tag));
        end else begin
            seen[pkt.tag]++;
            n_results++;
            if (u.fu == fu_mult) last_mult = cycle;
            check_cdb(pkt, exp_val[pkt.tag]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // mid-cycle sampling of the CDB and the occupancy bound
    always @(negedge clock) begin
        int outstanding;
        if (!reset && loaded) begin
            cycle++;
            for (int s = 0; s < n_way; s++) begin
                if (cdb[s].valid) record_result(s, cdb[s]);
            end
            // the slots on the port now are not accepted until the next edge
            outstanding = driven - dispatch[0].valid - dispatch[1].valid - n_results;
            if (outstanding - 2 > rs_size - n_way) check_level(almost_full, 1'b1);
            else if (outstanding <= rs_size - n_way) check_level(almost_full, 1'b0);
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = n_cases * (mult_cycles + 4) + 200;
        repeat (limit) @(posedge clock);
        abort_run($sformatf("timeout, results still missing after %0d cycles", limit));
    end

    initial begin
        int               idx;
        int               used;
        dispatch_packet_t pkt;
        reset    = 1'b1;
        dispatch = '0;
        load_cases();
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        check_level(almost_full, 1'b0);
        if (cdb[0].valid || cdb[1].valid) begin
            abort_run($sformatf("MISMATCH at %0t: CDB valid %b%b after reset, expected 00",
                                $time, cdb[1].valid, cdb[0].valid));
        end
        idx = 0;
        while (idx < n_cases) begin
            repeat (gap_q[idx]) begin
                dispatch = '0;
                next_cycle();
            end
            while (almost_full) begin   // hold back while the station is nearly full
                dispatch = '0;
                next_cycle();
            end
            pkt    = '0;
            pkt[0] = uop_q[idx];
            used   = 1;
            if (idx + 1 < n_cases && gap_q[idx + 1] == 0) begin
                pkt[1] = uop_q[idx + 1];
                used   = 2;
            end
            dispatch = pkt;
            driven  += used;
            idx     += used;
            next_cycle();
        end
        dispatch = '0;
        while (n_results < n_cases) next_cycle();
        repeat (mult_cycles + 4) next_cycle();   // room for a late duplicate
        check_level(almost_full, 1'b0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int period = 8
) (
    output logic clock
);

    initial clock = 1'b0;

    always #(period / 2) clock = ~clock;

endmodule

// ==== logic/issue_core.sv ====
module issue_core (
    input  logic                                                       clock,
    input  logic                                                       reset,
    input  issue_types_pkg::dispatch_packet_t                          dispatch,
    output logic                                                       almost_full,
    output issue_types_pkg::cdb_packet_t [issue_params_pkg::n_way-1:0] cdb
);

    import issue_types_pkg::*;

    fu_packet_t  fu_alu_packet;
    fu_packet_t  fu_mult_packet;
    logic        fu_mult_avail;
    cdb_packet_t alu_result;
    cdb_packet_t mult_result;

    assign cdb = {mult_result, alu_result};   // slot 0 alu, slot 1 mult

    rs i_rs (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .fu_mult_avail  (fu_mult_avail),
        .fu_alu_packet  (fu_alu_packet),
        .fu_mult_packet (fu_mult_packet),
        .almost_full    (almost_full)
    );

    fu_alu i_fu_alu (
        .clock  (clock),
        .reset  (reset),
        .packet (fu_alu_packet),
        .result (alu_result)
    );

    fu_mult i_fu_mult (
        .clock  (clock),
        .reset  (reset),
        .packet (fu_mult_packet),
        .avail  (fu_mult_avail),
        .result (mult_result)
    );

endmodule

// ==== logic/fu_mult.sv ====
module fu_mult (
    input  logic                         clock,
    input  logic                         reset,
    input  issue_types_pkg::fu_packet_t  packet,
    output logic                         avail,
    output issue_types_pkg::cdb_packet_t result
);

    import issue_params_pkg::*;

    logic                           busy;
    logic [$clog2(mult_cycles)-1:0] step;
    logic [xlen-1:0]                mcand;
    logic [xlen-1:0]                mplier;
    logic [xlen-1:0]                acc;
    logic [tag_width-1:0]           tag_q;
    logic [xlen-1:0]                partial;
    logic                           last_step;

    // one multiplier chunk per cycle, low xlen bits only
    assign partial   = mcand * mplier[mult_step_bits-1:0];
    assign last_step = busy && step == mult_cycles - 1;
    assign avail     = !busy && !packet.valid;

    always_ff @(posedge clock) begin
        if (packet.valid) begin
            mcand  <= packet.opa << mult_step_bits;
            mplier <= packet.opb >> mult_step_bits;
            acc    <= packet.opa * packet.opb[mult_step_bits-1:0];   // first chunk on arrival
            tag_q  <= packet.dest_tag;
        end else if (busy) begin
            mcand  <= mcand << mult_step_bits;
            mplier <= mplier >> mult_step_bits;
            acc    <= acc + partial;
        end
        result.tag   <= tag_q;
        result.value <= acc + partial;
        if (reset) begin
            busy         <= 1'b0;
            step         <= '0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= last_step;   // CDB slot 1, mult_cycles after issue
            if (packet.valid) begin
                busy <= 1'b1;
                step <= 1'b1;
            end else if (last_step) begin
                busy <= 1'b0;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    // the station must hold multiplies until avail
    assert property (@(posedge clock) disable iff (reset) packet.valid |-> !busy)
        else $error("fu_mult: packet issued while busy");

endmodule

// ==== logic/fu_alu.sv ====
module fu_alu (
    input  logic                         clock,
    input  logic                         reset,
    input  issue_types_pkg::fu_packet_t  packet,
    output issue_types_pkg::cdb_packet_t result
);

    import issue_params_pkg::*;
    import issue_types_pkg::*;

    logic [xlen-1:0] alu_out;

    always_comb begin
        case (packet.op)
            alu_add: alu_out = packet.opa + packet.opb;
            alu_sub: alu_out = packet.opa - packet.opb;
            alu_and: alu_out = packet.opa & packet.opb;
            alu_xor: alu_out = packet.opa ^ packet.opb;
        endcase
    end

    // result goes out on CDB slot 0 one cycle after issue
    always_ff @(posedge clock) begin
        result.tag   <= packet.dest_tag;
        result.value <= alu_out;
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= packet.valid;
        end
    end

endmodule

// ==== logic/rs.sv ====
module rs (
    input  logic                                                       clock,
    input  logic                                                       reset,
    input  issue_types_pkg::dispatch_packet_t                          dispatch,
    input  issue_types_pkg::cdb_packet_t [issue_params_pkg::n_way-1:0] cdb,
    input  logic                                                       fu_mult_avail,
    output issue_types_pkg::fu_packet_t                                fu_alu_packet,
    output issue_types_pkg::fu_packet_t                                fu_mult_packet,
    output logic                                                       almost_full
);

    import issue_params_pkg::*;
    import issue_types_pkg::*;

    rs_entry_t [rs_size-1:0] entries;
    rs_entry_t [rs_size-1:0] next_entries;
    logic [rs_cnt_width-1:0] counter;
    logic [rs_cnt_width-1:0] next_counter;
    fu_packet_t              next_alu_packet;
    fu_packet_t              next_mult_packet;

    logic [rs_size-1:0]                  entry_valid;
    logic [rs_size-1:0]                  wake;
    logic [rs_size-1:0]                  alu_req;
    logic [rs_size-1:0]                  mult_req;
    logic [num_fu_alu-1:0][rs_size-1:0]  alu_gnt_bus;
    logic [num_fu_mult-1:0][rs_size-1:0] mult_gnt_bus;
    logic [n_way-1:0]                    dispatch_valid;
    logic [n_way-1:0]                    accept;

    function automatic operand_t capture(operand_t opnd, cdb_packet_t [n_way-1:0] bus);
        operand_t res;
        res = opnd;
        for (int c = 0; c < n_way; c++) begin
            if (bus[c].valid && !res.ready && res.data[tag_width-1:0] == bus[c].tag) begin
                res.ready = 1'b1;
                res.data  = bus[c].value;
            end
        end
        return res;
    endfunction

    function automatic fu_packet_t to_packet(rs_entry_t e);
        fu_packet_t p;
        p.valid    = 1'b1;
        p.op       = e.op;
        p.opa      = e.op1.data;
        p.opb      = e.op2.data;
        p.dest_tag = e.dest_tag;
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            entry_valid[i] = entries[i].valid;
            wake[i]        = entries[i].valid && entries[i].op1.ready && entries[i].op2.ready;
            alu_req[i]     = wake[i] && entries[i].fu == fu_alu;
            mult_req[i]    = wake[i] && entries[i].fu == fu_mult;
        end
        for (int k = 0; k < n_way; k++) begin
            dispatch_valid[k] = dispatch[k].valid;
        end
    end

    assign accept      = almost_full ? '0 : dispatch_valid;
    assign almost_full = counter > (rs_size - n_way);

    psel_gen #(
        .WIDTH (rs_size),
        .REQS  (num_fu_alu)
    ) i_alu_sel (
        .req     (alu_req),
        .gnt_bus (alu_gnt_bus),
        .empty   ()
    );

    psel_gen #(
        .WIDTH (rs_size),
        .REQS  (num_fu_mult)
    ) i_mult_sel (
        .req     (mult_req),
        .gnt_bus (mult_gnt_bus),
        .empty   ()
    );

    always_comb begin
        logic placed;
        next_entries           = entries;
        next_counter           = counter;
        next_alu_packet        = fu_alu_packet;
        next_mult_packet       = fu_mult_packet;
        next_alu_packet.valid  = 1'b0;   // issue is a one-cycle pulse
        next_mult_packet.valid = 1'b0;
        for (int i = 0; i < rs_size; i++) begin
            if (alu_gnt_bus[0][i]) begin
                next_alu_packet       = to_packet(entries[i]);
                next_entries[i].valid = 1'b0;
                next_counter          = next_counter - 1'b1;
            end
            if (mult_gnt_bus[0][i] && fu_mult_avail) begin
                next_mult_packet      = to_packet(entries[i]);
                next_entries[i].valid = 1'b0;
                next_counter          = next_counter - 1'b1;
            end
        end
        // slots go to the lowest free entries, issuing entries are not reused
        for (int k = 0; k < n_way; k++) begin
            placed = 1'b0;
            for (int i = 0; i < rs_size; i++) begin
                if (accept[k] && !placed && !entries[i].valid && !next_entries[i].valid) begin
                    next_entries[i] = dispatch[k];
                    next_counter    = next_counter + 1'b1;
                    placed          = 1'b1;
                end
            end
        end
        for (int i = 0; i < rs_size; i++) begin
            next_entries[i].op1 = capture(next_entries[i].op1, cdb);   // covers new entries too
            next_entries[i].op2 = capture(next_entries[i].op2, cdb);
        end
    end

    always_ff @(posedge clock) begin
        entries        <= next_entries;
        fu_alu_packet  <= next_alu_packet;
        fu_mult_packet <= next_mult_packet;
        if (reset) begin
            counter              <= '0;
            fu_alu_packet.valid  <= 1'b0;
            fu_mult_packet.valid <= 1'b0;
            for (int i = 0; i < rs_size; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            counter <= next_counter;
        end
    end

    assert property (@(posedge clock) disable iff (reset) counter <= rs_size)
        else $error("rs: occupancy above capacity");

    assert property (@(posedge clock) disable iff (reset) almost_full |-> dispatch_valid == '0)
        else $error("rs: dispatch presented while almost_full, dropped");

    assert property (@(posedge clock) disable iff (reset) counter == $countones(entry_valid))
        else $error("rs: occupancy counter out of step with entries");

endmodule

// ==== logic/psel_gen.sv ====
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 1
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    // peel off the lowest remaining request for each grant
    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = req;
        for (int j = 0; j < REQS; j++) begin
            gnt_bus[j] = remaining & (~remaining + 1'b1);   // lowest set bit
            remaining  = remaining & ~gnt_bus[j];
        end
    end

    assign empty = ~|req;

    // no request may be granted twice
    always_comb begin
        logic [WIDTH-1:0] seen;
        seen = '0;
        for (int j = 0; j < REQS; j++) begin
            assert ((seen & gnt_bus[j]) == '0)
                else $error("psel_gen: request granted by more than one grant");
            seen = seen | gnt_bus[j];
        end
    end

endmodule

// ==== logic/issue_types_pkg.sv ====
package issue_types_pkg;

    import issue_params_pkg::*;

    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_kind_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_xor
    } alu_op_e;

    // data is the value when ready, else the pending tag in the low bits
    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] data;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        fu_kind_e             fu;
        alu_op_e              op;
        operand_t             op1;
        operand_t             op2;
        logic [tag_width-1:0] dest_tag;
    } rs_entry_t;

    typedef rs_entry_t [n_way-1:0] dispatch_packet_t;

    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [xlen-1:0]      opa;
        logic [xlen-1:0]      opb;
        logic [tag_width-1:0] dest_tag;
    } fu_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      value;
    } cdb_packet_t;

endpackage

// ==== logic/issue_params_pkg.sv ====
package issue_params_pkg;

    localparam int n_way        = 2;   // dispatch slots, also CDB slots
    localparam int rs_size      = 8;
    localparam int rs_cnt_width = 4;
    localparam int tag_width    = 5;   // 32 result tags
    localparam int xlen         = 32;

    localparam int num_fu_alu  = 1;
    localparam int num_fu_mult = 1;

    localparam int mult_cycles    = 4;
    localparam int mult_step_bits = xlen / mult_cycles;   // multiplier bits per step

endpackage
